/* logic/memPkg.sv */
`default_nettype none

package memPkg;

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        MSIZE1, MSIZE2, MSIZE4
    } mSize_t;

    typedef enum logic [1:0] {
        NONE, EXCEPTION, ERET
    } cType_t;

    // Top three address bits of the unmapped kernel segments
    localparam logic [2:0] kseg0Top = 3'b100;
    localparam logic [2:0] kseg1Top = 3'b101; // Uncached window

    typedef struct packed {
        logic adel; // Load address error
        logic ades; // Store address error
    } excBits_t;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg; // Load
        logic   memWrite; // Store
        logic   loWrite;
        logic   hiWrite;
        logic   cp0Write;
        mSize_t mSize;
    } ctlBits_t;

    typedef struct packed {
        cType_t   cType;
        logic     valid;
        excBits_t eType;
        word_t    badVaddr;
    } cp0Ctl_t;

    // One instruction leaving execute
    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [4:0] rDst;
        word_t      aluOut;  // Effective address for memory ops
        word_t      srcB;    // Raw store data
        logic       isSlot;  // Sits in a branch delay slot
        ctlBits_t   ctl;
        cp0Ctl_t    cp0Ctl;
    } execData_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;    // Physical
        mSize_t     size;
        logic [3:0] strobe;
        word_t      data;
        logic       uncached;
    } dbusReq_t;

    // Per-lane result handed to the arbiter
    typedef struct packed {
        word_t      paddr;
        logic       uncached;
        word_t      wData;
        logic [3:0] strobe;
        logic       loadMisalign;
        logic       storeMisalign;
    } laneInfo_t;

endpackage

`default_nettype wire

/* logic/execMemReg.sv */
`timescale 1ns/1ps
`default_nettype none

module execMemReg (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              stall,
    input  wire logic              flush,
    input  memPkg::execData_t      dataE [1:0],
    output memPkg::execData_t      dataR [1:0]
);

    memPkg::execData_t entry [1:0];

    // Stall beats flush, flush beats new data
    always_ff @(posedge clk) begin
        if (!rstN) begin
            entry[0] <= '0;
            entry[1] <= '0;
        end else if (!stall) begin
            if (flush) begin
                entry[0] <= '0; // Both lanes killed
                entry[1] <= '0;
            end else begin
                entry[0] <= dataE[0];
                entry[1] <= dataE[1];
            end
        end
    end

    assign dataR[0] = entry[0];
    assign dataR[1] = entry[1];

endmodule

`default_nettype wire

/* logic/memLane.sv */
`timescale 1ns/1ps
`default_nettype none

module memLane (
    input  memPkg::execData_t  inst,
    output memPkg::laneInfo_t  info
);

    memPkg::word_t vaddr;
    logic [1:0]    offset;
    logic [2:0]    segTop;
    logic          inKseg0;
    logic          inKseg1;
    logic          misaligned;
    logic [3:0]    rawStrobe;
    memPkg::word_t rawData;

    assign vaddr   = inst.aluOut;
    assign offset  = vaddr[1:0];
    assign segTop  = vaddr[31:29];
    assign inKseg0 = (segTop == memPkg::kseg0Top);
    assign inKseg1 = (segTop == memPkg::kseg1Top);

    // Fixed segment map, no TLB
    always_comb begin
        if (inKseg0 || inKseg1) begin
            info.paddr = {3'b000, vaddr[28:0]};
        end else begin
            info.paddr = vaddr; // kuseg and kseg2/3 untouched
        end
        info.uncached = inKseg1;
    end

    // Replicate store data across the word and pick byte lanes
    always_comb begin
        rawData   = inst.srcB;
        rawStrobe = 4'b0000;
        case (inst.ctl.mSize)
            memPkg::MSIZE1: begin
                rawData   = {4{inst.srcB[7:0]}};
                rawStrobe = 4'b0001 << offset;
            end
            memPkg::MSIZE2: begin
                rawData   = {2{inst.srcB[15:0]}};
                rawStrobe = offset[1] ? 4'b1100 : 4'b0011;
            end
            memPkg::MSIZE4: begin
                rawStrobe = 4'b1111;
            end
            default: begin
                rawStrobe = 4'b0000; // Unused size code writes nothing
            end
        endcase
    end

    always_comb begin
        case (inst.ctl.mSize)
            memPkg::MSIZE2: misaligned = offset[0];
            memPkg::MSIZE4: misaligned = (offset != 2'b00);
            default:        misaligned = 1'b0;
        endcase
    end

    // Both flags gated by their own enable
    assign info.loadMisalign  = inst.ctl.memToReg && misaligned;
    assign info.storeMisalign = inst.ctl.memWrite && misaligned;

    assign info.wData  = rawData;
    assign info.strobe = info.storeMisalign ? 4'b0000 : rawStrobe;

endmodule

`default_nettype wire

/* logic/memArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  memPkg::execData_t  inst [1:0],
    input  memPkg::laneInfo_t  info [1:0],
    input  wire logic [1:0]    reqFinish,
    output memPkg::dbusReq_t   dReq [1:0],
    output memPkg::execData_t  dataM [1:0],
    output logic               excpM
);

    logic [1:0] trap;       // Exception or ERET already tagged upstream
    logic [1:0] misalign;   // Valid lane with an address error
    logic [1:0] fault;
    logic [1:0] memOp;
    logic [1:0] canIssue;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            trap[i]     = (inst[i].cp0Ctl.cType == memPkg::EXCEPTION) ||
                          (inst[i].cp0Ctl.cType == memPkg::ERET);
            misalign[i] = inst[i].valid &&
                          (info[i].loadMisalign || info[i].storeMisalign);
            fault[i]    = inst[i].valid && (trap[i] || misalign[i]);
            memOp[i]    = inst[i].ctl.memToReg || inst[i].ctl.memWrite;
            canIssue[i] = inst[i].valid && memOp[i] && !fault[i] && !reqFinish[i];
        end
    end

    // Bus requests
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dReq[i] = '0;
            if (memOp[i]) begin
                dReq[i].addr     = info[i].paddr;
                dReq[i].size     = inst[i].ctl.mSize;
                dReq[i].uncached = info[i].uncached;
                if (!inst[i].ctl.memToReg) begin // Loads keep strobe and data at 0
                    dReq[i].strobe = info[i].strobe;
                    dReq[i].data   = info[i].wData;
                end
            end
        end
        dReq[1].valid = canIssue[1];
        dReq[0].valid = canIssue[0] && !fault[1]; // Younger lane waits on older
    end

    // Exception rewrite and younger-lane squash
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dataM[i] = inst[i];
            if (misalign[i]) begin
                dataM[i].cp0Ctl.cType      = memPkg::EXCEPTION;
                dataM[i].cp0Ctl.valid      = 1'b1;
                dataM[i].cp0Ctl.eType.adel = info[i].loadMisalign;
                dataM[i].cp0Ctl.eType.ades = info[i].storeMisalign;
                dataM[i].cp0Ctl.badVaddr   = inst[i].aluOut;
            end
        end

        if (fault[1]) begin
            dataM[0].ctl.regWrite = 1'b0;
            dataM[0].ctl.memToReg = 1'b0;
            dataM[0].ctl.loWrite  = 1'b0;
            dataM[0].ctl.hiWrite  = 1'b0;
            dataM[0].ctl.cp0Write = 1'b0;
        end
        if (misalign[1]) begin
            dataM[0].cp0Ctl.valid = 1'b0; // Older address error wins CP0
        end
    end

    assign excpM = |fault;

endmodule

`default_nettype wire

/* logic/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          stall,
    input  wire logic          flush,
    input  memPkg::execData_t  dataE [1:0],
    input  wire logic [1:0]    reqFinish,
    output memPkg::dbusReq_t   dReq [1:0],
    output memPkg::execData_t  dataM [1:0],
    output logic               excpM
);

    memPkg::execData_t dataR [1:0];
    memPkg::laneInfo_t info [1:0];

    execMemReg execMemRegInst (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .dataE (dataE),
        .dataR (dataR)
    );

    // Lane 0 younger, lane 1 older
    memLane lane0 (
        .inst (dataR[0]),
        .info (info[0])
    );

    memLane lane1 (
        .inst (dataR[1]),
        .info (info[1])
    );

    memArbiter memArbiterInst (
        .inst      (dataR),
        .info      (info),
        .reqFinish (reqFinish),
        .dReq      (dReq),
        .dataM     (dataM),
        .excpM     (excpM)
    );

endmodule

`default_nettype wire

/* testbench/memModel.svh */
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// kseg0 is 100, kseg1 is 101 in the top three address bits
function automatic memPkg::word_t physAddr(input memPkg::word_t va);
    memPkg::word_t pa;
    pa = va;
    if (va[31:30] == 2'b10) begin
        pa[31:29] = 3'b000; // Both unmapped kernel windows fold onto low memory
    end
    return pa;
endfunction

function automatic logic isUncached(input memPkg::word_t va);
    return va[31:29] == 3'b101;
endfunction

function automatic logic sizeMisaligned(input memPkg::mSize_t size, input memPkg::word_t va);
    if (size == memPkg::MSIZE2) return va[0];
    if (size == memPkg::MSIZE4) return va[1] | va[0];
    return 1'b0;
endfunction

function automatic logic [3:0] storeStrobe(input memPkg::mSize_t size, input memPkg::word_t va);
    logic [3:0] s;
    s = 4'b0000;
    if (size == memPkg::MSIZE1) begin
        s[va[1:0]] = 1'b1;
    end else if (size == memPkg::MSIZE2) begin
        s = va[1] ? 4'b1100 : 4'b0011; // Upper or lower half
    end else if (size == memPkg::MSIZE4) begin
        s = 4'b1111;
    end
    return s;
endfunction

function automatic memPkg::word_t storeData(input memPkg::mSize_t size, input memPkg::word_t b);
    if (size == memPkg::MSIZE1) return {b[7:0], b[7:0], b[7:0], b[7:0]};
    if (size == memPkg::MSIZE2) return {b[15:0], b[15:0]};
    return b;
endfunction

function automatic logic loadMisaligned(input memPkg::execData_t d);
    return d.ctl.memToReg && sizeMisaligned(d.ctl.mSize, d.aluOut);
endfunction

function automatic logic storeMisaligned(input memPkg::execData_t d);
    return d.ctl.memWrite && sizeMisaligned(d.ctl.mSize, d.aluOut);
endfunction

function automatic logic laneFaults(input memPkg::execData_t d);
    logic trapped;
    trapped = (d.cp0Ctl.cType == memPkg::EXCEPTION) || (d.cp0Ctl.cType == memPkg::ERET);
    return d.valid && (trapped || loadMisaligned(d) || storeMisaligned(d));
endfunction

function automatic memPkg::dbusReq_t predictReq(input memPkg::execData_t d,
                                                input logic finished,
                                                input logic olderFault);
    memPkg::dbusReq_t r;
    r = '0;
    r.valid    = d.valid && (d.ctl.memToReg || d.ctl.memWrite) && !laneFaults(d)
                 && !finished && !olderFault;
    r.addr     = physAddr(d.aluOut);
    r.size     = d.ctl.mSize;
    r.uncached = isUncached(d.aluOut);
    if (d.ctl.memWrite && !d.ctl.memToReg) begin
        r.strobe = storeStrobe(d.ctl.mSize, d.aluOut);
        r.data   = storeData(d.ctl.mSize, d.srcB);
    end
    return r;
endfunction

function automatic memPkg::execData_t predictDataM(input memPkg::execData_t d,
                                                   input memPkg::execData_t older,
                                                   input logic isYounger);
    memPkg::execData_t r;
    r = d;
    if (d.valid && (loadMisaligned(d) || storeMisaligned(d))) begin
        r.cp0Ctl.cType      = memPkg::EXCEPTION;
        r.cp0Ctl.valid      = 1'b1;
        r.cp0Ctl.eType.adel = loadMisaligned(d);
        r.cp0Ctl.eType.ades = storeMisaligned(d);
        r.cp0Ctl.badVaddr   = d.aluOut;
    end
    if (isYounger && laneFaults(older)) begin
        r.ctl.regWrite = 1'b0;
        r.ctl.memToReg = 1'b0;
        r.ctl.loWrite  = 1'b0;
        r.ctl.hiWrite  = 1'b0;
        r.ctl.cp0Write = 1'b0;
    end
    if (isYounger && older.valid && (loadMisaligned(older) || storeMisaligned(older))) begin
        r.cp0Ctl.valid = 1'b0;
    end
    return r;
endfunction

`endif

/* testbench/memStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memStageTb;

    localparam int resetCycles = 3;
    localparam int numCycles   = 3000;
    localparam int timeoutNs   = (numCycles + resetCycles + 1) * 40 + 400;

    logic              clk;
    logic              rstN;
    logic              stall;
    logic              flush;
    logic [1:0]        reqFinish;
    memPkg::execData_t dataE [1:0];
    memPkg::dbusReq_t  dReq [1:0];
    memPkg::execData_t dataM [1:0];
    logic              excpM;
    memPkg::execData_t modelReg [1:0];

    `include "memModel.svh"

    memStage uut (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .flush     (flush),
        .dataE     (dataE),
        .reqFinish (reqFinish),
        .dReq      (dReq),
        .dataM     (dataM),
        .excpM     (excpM)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Reference copy of the pipeline register
    always @(posedge clk) begin
        if (!rstN || (flush && !stall)) begin
            modelReg[0] <= '0;
            modelReg[1] <= '0;
        end else if (!stall) begin
            modelReg[0] <= dataE[0];
            modelReg[1] <= dataE[1];
        end
    end

    task automatic compareValue(input string testName, input logic [159:0] expected,
                                input logic [159:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", testName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    function automatic memPkg::execData_t randomInst();
        memPkg::execData_t d;
        memPkg::word_t     r;
        int unsigned       kind;
        int unsigned       sz;
        int unsigned       ct;
        d    = '0;
        kind = $urandom % 3; // Load, store or other
        sz   = $urandom % 3;
        ct   = $urandom % 16;
        r    = $urandom;
        d.valid  = ($urandom % 5) != 0;
        d.pc     = {r[31:2], 2'b00};
        d.rDst   = r[4:0];
        d.srcB   = $urandom;
        d.isSlot = ($urandom % 2) == 1;
        d.aluOut = $urandom;
        case ($urandom % 3)
            0: d.aluOut[31]    = 1'b0;   // kuseg
            1: d.aluOut[31:29] = 3'b100;
            default: d.aluOut[31:29] = 3'b101;
        endcase
        if (($urandom % 2) == 1) begin
            if (sz == 1) d.aluOut[0] = 1'b0;
            if (sz == 2) d.aluOut[1:0] = 2'b00;
        end
        d.ctl.mSize    = memPkg::mSize_t'(sz);
        d.ctl.memToReg = kind == 0;
        d.ctl.memWrite = kind == 1;
        d.ctl.regWrite = (kind == 0) || ((kind == 2) && (($urandom % 2) == 1));
        d.ctl.loWrite  = ($urandom % 2) == 1;
        d.ctl.hiWrite  = ($urandom % 2) == 1;
        d.ctl.cp0Write = ($urandom % 2) == 1;
        d.cp0Ctl.cType = (ct < 2) ? memPkg::EXCEPTION : ((ct == 2) ? memPkg::ERET : memPkg::NONE);
        d.cp0Ctl.valid    = d.cp0Ctl.cType != memPkg::NONE;
        d.cp0Ctl.badVaddr = $urandom;
        return d;
    endfunction

    task automatic driveStimulus(input logic allowCapture);
        dataE[0]  = randomInst();
        dataE[1]  = randomInst();
        stall     = !allowCapture || (($urandom % 5) == 0);
        flush     = ($urandom % 8) == 0;
        reqFinish = {($urandom % 4) == 0, ($urandom % 4) == 0};
    endtask

    task automatic checkIdle(input string testName);
        compareValue({testName, " dReq0.valid"}, 1'b0, dReq[0].valid);
        compareValue({testName, " dReq1.valid"}, 1'b0, dReq[1].valid);
        compareValue({testName, " excpM"}, 1'b0, excpM);
        compareValue({testName, " dataM0"}, '0, dataM[0]);
        compareValue({testName, " dataM1"}, '0, dataM[1]);
    endtask

    task automatic checkOutputs(input int cycle);
        memPkg::dbusReq_t  expReq;
        memPkg::execData_t expData;
        logic              olderFault;
        string             tag;
        olderFault = laneFaults(modelReg[1]);
        for (int i = 0; i < 2; i++) begin
            tag    = $sformatf("cycle %0d lane%0d", cycle, i);
            expReq = predictReq(modelReg[i], reqFinish[i], (i == 0) && olderFault);
            compareValue({tag, " dReq.valid"}, expReq.valid, dReq[i].valid);
            if (expReq.valid) begin // Payload only matters on a live request
                compareValue({tag, " dReq.addr"}, expReq.addr, dReq[i].addr);
                compareValue({tag, " dReq.size"}, expReq.size, dReq[i].size);
                compareValue({tag, " dReq.strobe"}, expReq.strobe, dReq[i].strobe);
                compareValue({tag, " dReq.data"}, expReq.data, dReq[i].data);
                compareValue({tag, " dReq.uncached"}, expReq.uncached, dReq[i].uncached);
            end
            expData = predictDataM(modelReg[i], modelReg[1], i == 0);
            compareValue({tag, " dataM"}, expData, dataM[i]);
        end
        compareValue($sformatf("cycle %0d excpM", cycle),
                     predictExcpFlag(modelReg[0], modelReg[1]), excpM);
    endtask

    function automatic logic predictExcpFlag(input memPkg::execData_t d0,
                                             input memPkg::execData_t d1);
        return laneFaults(d0) || laneFaults(d1);
    endfunction

    initial begin
        void'($urandom(32'hbdc8bc3e));
        rstN      = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        reqFinish = 2'b00;
        dataE[0]  = '0;
        dataE[1]  = '0;

        for (int c = 0; c < resetCycles; c++) begin
            @(posedge clk);
            #2;
            driveStimulus(c != resetCycles - 1); // First edge out of reset captures nothing
            if (c == resetCycles - 1) begin
                rstN = 1'b1;
            end
            @(negedge clk);
            checkIdle("reset");
        end

        @(posedge clk);
        #2;
        driveStimulus(1'b1);
        @(negedge clk);
        checkIdle("after reset");

        for (int c = 0; c < numCycles; c++) begin
            @(posedge clk);
            #2;
            driveStimulus(1'b1);
            @(negedge clk);
            checkOutputs(c);
        end

        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("error: watchdog expired before the stimulus finished");
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

/* memStage.f */
+incdir+testbench
logic/memPkg.sv
logic/execMemReg.sv
logic/memLane.sv
logic/memArbiter.sv
logic/memStage.sv
testbench/memStageTb.sv
